// File: list.f
+incdir+logic
logic/scuRegPkg.sv
logic/scuIntPkg.sv
logic/intSources.sv
logic/intStatus.sv
logic/intArbiter.sv
logic/scuIntCtrl.sv
sim/scuIntCtrl_sva.sv
sim/scuIntCtrl_tb.sv

// File: logic/intArbiter.sv
`default_nettype none

`include "scu_defines.svh"

module intArbiter
	import scuIntPkg::*;
(
	input  wire           CLK,
	input  wire           RST_N,
	input  wire srcMask_t pending,
	input  wire           istWritten,
	input  wire           vecRead,
	input  wire intLevel_t vecLevel,
	output intVector_t    vecData,
	output srcMask_t      ackClear,
	output logic [3:0]    irlN
);

	arbState_t  state;
	intLevel_t  level;
	intSrc_t    topSrc;
	srcMask_t   ackSel;
	intVector_t vecNext;

	// Fixed priority, lowest IST bit first
	always_comb begin
		topSrc = srcTm1;
		for (int i = `SCU_SRC_N - 1; i >= 0; i--) begin
			if (pending[i])
				topSrc = intSrc_t'(i);
		end
	end

	// Source that owns the level being fetched
	always_comb begin
		ackSel = '0;
		vecNext = '0;
		for (int i = 0; i < `SCU_SRC_N; i++) begin
			if (vecLevel == srcLevel(intSrc_t'(i))) begin
				vecNext = srcVector(intSrc_t'(i));
				ackSel[i] = 1'b1;
			end
		end
	end

	assign ackClear = vecRead ? ackSel : '0;

	// Level is latched once and held until fetched or IST is written
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= arbIdle;
			level <= '0;
		end else if (vecRead || istWritten) begin
			state <= arbIdle;
			level <= '0;
		end else begin
			case (state)
				arbIdle: begin
					if (|pending) begin
						level <= srcLevel(topSrc);
						state <= arbHold;
					end
				end
				arbHold: begin
					level <= level;
				end
				default: state <= arbIdle;
			endcase
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			vecData <= '0;
		end else if (vecRead) begin
			vecData <= vecNext;
		end
	end

	assign irlN = ~level;

endmodule

`default_nettype wire

// File: logic/intSources.sv
`default_nettype none

`include "scu_defines.svh"

module intSources
	import scuRegPkg::*, scuIntPkg::*;
(
	input  wire         CLK,
	input  wire         RST_N,
	input  wire         vBlankN,
	input  wire         hBlankN,
	input  wire         regWrite,
	input  wire  [7:0]  regAddr,
	input  wire  [31:0] regWData,
	input  wire  [3:0]  regByteEnN,
	output srcMask_t    srcEvent
);

	logic vbSync;
	logic vbOld;
	logic hbSync;
	logic hbOld;
	logic vbFall;
	logic vbRise;
	logic hbFall;

	logic [`SCU_T0C_W-1:0] t0c;
	logic [`SCU_T1S_W-1:0] t1s;
	logic                  t1Enb;
	timerMode_t            t1Mode;

	logic [`SCU_T0C_W-1:0] tm0Cnt;
	logic [`SCU_TM1_W-1:0] tm1Cnt;
	logic                  t1Qual;
	logic                  tm0Hit;
	logic                  tm1Hit;

	// Blanking levels, idle high
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			vbSync <= 1'b1;
			vbOld <= 1'b1;
			hbSync <= 1'b1;
			hbOld <= 1'b1;
		end else begin
			vbSync <= vBlankN;
			vbOld <= vbSync;
			hbSync <= hBlankN;
			hbOld <= hbSync;
		end
	end

	assign vbFall = vbOld & ~vbSync;
	assign vbRise = ~vbOld & vbSync;
	assign hbFall = hbOld & ~hbSync;

	// Timer registers, byte-wise writes
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			t0c <= '0;
			t1s <= '0;
			t1Enb <= 1'b0;
			t1Mode <= tmEveryLine;
		end else if (regWrite) begin
			case (regAddr)
				ofsT0c: begin
					if (!regByteEnN[0])
						t0c[7:0] <= regWData[7:0];
					if (!regByteEnN[1])
						t0c[`SCU_T0C_W-1:8] <= regWData[`SCU_T0C_W-1:8];
				end
				ofsT1s: begin
					if (!regByteEnN[0])
						t1s[7:0] <= regWData[7:0];
					if (!regByteEnN[1])
						t1s[`SCU_T1S_W-1:8] <= regWData[`SCU_T1S_W-1:8];
				end
				ofsT1md: begin
					if (!regByteEnN[0])
						t1Enb <= regWData[`SCU_T1MD_ENB_BIT];
					if (!regByteEnN[1])
						t1Mode <= timerMode_t'(regWData[`SCU_T1MD_MD_BIT]);
				end
				default: ;
			endcase
		end
	end

	assign tm0Hit = t1Enb & hbFall & (tm0Cnt == t0c);
	assign tm1Hit = t1Enb & t1Qual & (tm1Cnt == '0);

	// Timer 0 counts lines since blank-out, timer 1 runs within the line
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			tm0Cnt <= '0;
			tm1Cnt <= '0;
			t1Qual <= 1'b0;
		end else if (t1Enb) begin
			tm1Cnt <= tm1Cnt - 1'b1;
			if (tm1Hit)
				t1Qual <= 1'b0;
			if (hbFall) begin
				tm0Cnt <= tm0Cnt + 1'b1;
				tm1Cnt <= {t1s, 2'b11};
				t1Qual <= (t1Mode == tmEveryLine) | tm0Hit;
			end
			if (vbRise)
				tm0Cnt <= '0;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			srcEvent <= '0;
		end else begin
			srcEvent[srcVbIn] <= vbFall;
			srcEvent[srcVbOut] <= vbRise;
			srcEvent[srcHbIn] <= hbFall;
			srcEvent[srcTm0] <= tm0Hit;
			srcEvent[srcTm1] <= tm1Hit;
		end
	end

endmodule

`default_nettype wire

// File: logic/intStatus.sv
`default_nettype none

`include "scu_defines.svh"

module intStatus
	import scuRegPkg::*, scuIntPkg::*;
(
	input  wire          CLK,
	input  wire          RST_N,
	input  wire srcMask_t srcEvent,
	input  wire srcMask_t ackClear,
	input  wire          regWrite,
	input  wire          regRead,
	input  wire  [7:0]   regAddr,
	input  wire  [31:0]  regWData,
	input  wire  [3:0]   regByteEnN,
	output logic [31:0]  regRData,
	output srcMask_t     pending,
	output logic         istWritten
);

	srcMask_t ist;
	srcMask_t ims;
	srcMask_t wrClear;
	logic     imsWrite;

	assign istWritten = regWrite & (regAddr == ofsIst);
	assign imsWrite = regWrite & (regAddr == ofsIms) & ~regByteEnN[0];

	// Zero bits of the written word clear the matching IST bits
	assign wrClear = (istWritten && !regByteEnN[0]) ? ~regWData[`SCU_SRC_N-1:0] : '0;

	// New events win over a clear in the same cycle
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ist <= '0;
		end else begin
			ist <= (ist & ~wrClear & ~ackClear) | srcEvent;
		end
	end

	// All sources masked out of reset
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ims <= '1;
		end else if (imsWrite) begin
			ims <= regWData[`SCU_SRC_N-1:0];
		end
	end

	assign pending = ist & ~ims;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			regRData <= '0;
		end else if (regRead) begin
			if (regAddr == ofsIst)
				regRData <= {{(32-`SCU_SRC_N){1'b0}}, ist};
			else
				regRData <= '0;
		end
	end

endmodule

`default_nettype wire

// File: logic/scuIntCtrl.sv
`default_nettype none

module scuIntCtrl
	import scuIntPkg::*;
(
	input  wire         CLK,
	input  wire         RST_N,

	input  wire         regWrite,
	input  wire  [7:0]  regAddr,
	input  wire  [31:0] regWData,
	input  wire  [3:0]  regByteEnN,
	input  wire         regRead,
	output logic [31:0] regRData,

	input  wire         vecRead,
	input  wire  [3:0]  vecLevel,
	output logic [7:0]  vecData,
	output logic [3:0]  irlN,

	input  wire         vBlankN,
	input  wire         hBlankN
);

	srcMask_t srcEvent;
	srcMask_t pending;
	srcMask_t ackClear;
	logic     istWritten;

	intSources sources (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.vBlankN    (vBlankN),
		.hBlankN    (hBlankN),
		.regWrite   (regWrite),
		.regAddr    (regAddr),
		.regWData   (regWData),
		.regByteEnN (regByteEnN),
		.srcEvent   (srcEvent)
	);

	intStatus status (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.srcEvent   (srcEvent),
		.ackClear   (ackClear),
		.regWrite   (regWrite),
		.regRead    (regRead),
		.regAddr    (regAddr),
		.regWData   (regWData),
		.regByteEnN (regByteEnN),
		.regRData   (regRData),
		.pending    (pending),
		.istWritten (istWritten)
	);

	intArbiter arbiter (
		.CLK        (CLK),
		.RST_N      (RST_N),
		.pending    (pending),
		.istWritten (istWritten),
		.vecRead    (vecRead),
		.vecLevel   (vecLevel),
		.vecData    (vecData),
		.ackClear   (ackClear),
		.irlN       (irlN)
	);

endmodule

`default_nettype wire

// File: logic/scuIntPkg.sv
`default_nettype none

`include "scu_defines.svh"

package scuIntPkg;

	// IST bit positions, lowest bit has highest priority
	typedef enum logic [2:0] {
		srcVbIn  = 3'd0,
		srcVbOut = 3'd1,
		srcHbIn  = 3'd2,
		srcTm0   = 3'd3,
		srcTm1   = 3'd4
	} intSrc_t;

	typedef logic [`SCU_SRC_N-1:0] srcMask_t;
	typedef logic [3:0] intLevel_t;
	typedef logic [7:0] intVector_t;

	typedef enum logic {
		arbIdle,
		arbHold
	} arbState_t;

	// Level F for bit 0, one lower per bit
	function automatic intLevel_t srcLevel(intSrc_t src);
		return intLevel_t'(4'hF - 4'(src));
	endfunction

	function automatic intVector_t srcVector(intSrc_t src);
		return intVector_t'(`SCU_VEC_BASE + 8'(src));
	endfunction

endpackage

`default_nettype wire

// File: logic/scuRegPkg.sv
`default_nettype none

`include "scu_defines.svh"

package scuRegPkg;

	// Register map of the interrupt section
	typedef enum logic [7:0] {
		ofsT0c  = `SCU_T0C_OFS,
		ofsT1s  = `SCU_T1S_OFS,
		ofsT1md = `SCU_T1MD_OFS,
		ofsIms  = `SCU_IMS_OFS,
		ofsIst  = `SCU_IST_OFS
	} regOfs_t;

	// T1MD mode bit
	typedef enum logic {
		tmEveryLine = 1'b0,
		tmMatchLine = 1'b1
	} timerMode_t;

endpackage

`default_nettype wire

// File: logic/scu_defines.svh
`ifndef SCU_DEFINES_SVH
`define SCU_DEFINES_SVH

// Register byte offsets, one word each
`define SCU_T0C_OFS  8'h90
`define SCU_T1S_OFS  8'h94
`define SCU_T1MD_OFS 8'h98
`define SCU_IMS_OFS  8'hA0
`define SCU_IST_OFS  8'hA4

// Timer field widths
`define SCU_T0C_W 10
`define SCU_T1S_W 9
`define SCU_TM1_W 11

// Kept interrupt sources
`define SCU_SRC_N    5
`define SCU_VEC_BASE 8'h40

// T1MD field positions
`define SCU_T1MD_ENB_BIT 0
`define SCU_T1MD_MD_BIT  8

`endif

// File: sim/scuIntCtrl_sva.sv
`default_nettype none

`include "scu_defines.svh"

module scuIntCtrl_sva
	import scuIntPkg::*;
(
	input wire           CLK,
	input wire           RST_N,
	input wire [3:0]     irlN,
	input wire [7:0]     vecData,
	input wire srcMask_t pending
);

	logic violated = 1'b0;

	// Leaving idle needs a pending source one cycle earlier
	raiseNeedsPending: assert property (@(posedge CLK) disable iff (!RST_N)
		(irlN != 4'hF && $past(irlN) == 4'hF) |-> $past(|pending))
		else begin
			$error("irlN left idle with nothing pending");
			violated = 1'b1;
		end

	levelViaIdle: assert property (@(posedge CLK) disable iff (!RST_N)
		(irlN != $past(irlN)) |-> (irlN == 4'hF || $past(irlN) == 4'hF))
		else begin
			$error("irlN moved between two levels without passing idle");
			violated = 1'b1;
		end

	vectorRange: assert property (@(posedge CLK) disable iff (!RST_N)
		vecData == 8'h00 ||
		(vecData >= `SCU_VEC_BASE && vecData < `SCU_VEC_BASE + `SCU_SRC_N))
		else begin
			$error("vecData outside the vector range");
			violated = 1'b1;
		end

endmodule

bind scuIntCtrl scuIntCtrl_sva props (
	.CLK     (CLK),
	.RST_N   (RST_N),
	.irlN    (irlN),
	.vecData (vecData),
	.pending (pending)
);

`default_nettype wire

// File: sim/scuIntCtrl_tb.sv
`default_nettype none

`include "scu_defines.svh"

module scuIntCtrl_tb;

	typedef enum {
		opWrite,
		opRead,
		opPulse,
		opWaitIrl,
		opVecRead
	} opKind_t;

	typedef struct {
		opKind_t     op;
		logic [7:0]  addr;
		logic [31:0] data;
		logic [31:0] expVal;
	} row_t;

	localparam logic [7:0] selVBlank = 8'd0;
	localparam logic [7:0] selHBlank = 8'd1;
	localparam int waitLimit = 64;

	logic        CLK;
	logic        RST_N;
	logic        regWrite;
	logic [7:0]  regAddr;
	logic [31:0] regWData;
	logic [3:0]  regByteEnN;
	logic        regRead;
	logic [31:0] regRData;
	logic        vecRead;
	logic [3:0]  vecLevel;
	logic [7:0]  vecData;
	logic [3:0]  irlN;
	logic        vBlankN;
	logic        hBlankN;

	row_t       rows[$];
	logic [7:0] lfsrState;

	scuIntCtrl dut (.*);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	task automatic stopRun(input string reason);
		$display("%s", reason);
		$display("Simulation FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	// Galois form, taps 8 6 5 4
	function automatic logic [7:0] lfsrNext(input logic [7:0] s);
		if (s[0])
			return (s >> 1) ^ 8'hB8;
		else
			return s >> 1;
	endfunction

	task automatic idleGap();
		int n;
		n = 0;
		repeat (2) begin
			n = (n << 1) | lfsrState[0];
			lfsrState = lfsrNext(lfsrState);
		end
		repeat (n) @(negedge CLK);
	endtask

	task automatic addRow(input opKind_t op, input logic [7:0] addr,
		input logic [31:0] data, input logic [31:0] expVal);
		row_t r;
		r.op = op;
		r.addr = addr;
		r.data = data;
		r.expVal = expVal;
		rows.push_back(r);
	endtask

	task automatic writeReg(input logic [7:0] addr, input logic [31:0] data);
		regWrite = 1'b1;
		regAddr = addr;
		regWData = data;
		regByteEnN = 4'h0;
		@(negedge CLK);
		regWrite = 1'b0;
		regWData = '0;
		regByteEnN = 4'hF;
	endtask

	task automatic readReg(input logic [7:0] addr, input logic [31:0] expVal);
		regRead = 1'b1;
		regAddr = addr;
		@(negedge CLK);
		regRead = 1'b0;
		assert (regRData === expVal)
		else stopRun($sformatf("mismatch at time %0t: register %h read %h, expected %h",
			$time, addr, regRData, expVal));
	endtask

	// Low then high again, long enough for timer 1 to expire
	task automatic pulseBlank(input logic [7:0] sel);
		if (sel == selVBlank)
			vBlankN = 1'b0;
		else
			hBlankN = 1'b0;
		repeat (4) @(negedge CLK);
		vBlankN = 1'b1;
		hBlankN = 1'b1;
		repeat (12) @(negedge CLK);
	endtask

	task automatic waitIrl(input logic [3:0] expIrl);
		int n;
		n = 0;
		while (irlN !== expIrl && n < waitLimit) begin
			@(negedge CLK);
			n++;
		end
		assert (irlN === expIrl)
		else stopRun($sformatf("timeout at time %0t: irlN stayed %h while waiting for %h",
			$time, irlN, expIrl));
	endtask

	task automatic fetchVector(input logic [3:0] level, input logic [7:0] expVec);
		vecRead = 1'b1;
		vecLevel = level;
		@(negedge CLK);
		vecRead = 1'b0;
		assert (vecData === expVec)
		else stopRun($sformatf("mismatch at time %0t: vector at level %h was %h, expected %h",
			$time, level, vecData, expVec));
	endtask

	task automatic buildTable();
		addRow(opWaitIrl, 0, 0, 4'hF);
		addRow(opRead, `SCU_IST_OFS, 0, 32'h00);
		// vbIn unmasked, fetched at level F
		addRow(opWrite, `SCU_IMS_OFS, 32'h1E, 0);
		addRow(opPulse, selVBlank, 0, 0);
		addRow(opRead, `SCU_IST_OFS, 0, 32'h03);
		addRow(opWaitIrl, 0, 0, 4'h0);
		addRow(opVecRead, 4'hF, 0, 8'h40);
		addRow(opWaitIrl, 0, 0, 4'hF);
		addRow(opWrite, `SCU_IST_OFS, 32'h1D, 0);
		addRow(opRead, `SCU_IST_OFS, 0, 32'h00);
		// hbIn held back by its mask bit
		addRow(opPulse, selHBlank, 0, 0);
		addRow(opRead, `SCU_IST_OFS, 0, 32'h04);
		addRow(opWaitIrl, 0, 0, 4'hF);
		addRow(opWrite, `SCU_IMS_OFS, 32'h1A, 0);
		addRow(opWaitIrl, 0, 0, 4'h2);
		addRow(opVecRead, 4'hD, 0, 8'h42);
		// vbOut and hbIn unmasked together
		addRow(opWrite, `SCU_IMS_OFS, 32'h1F, 0);
		addRow(opPulse, selVBlank, 0, 0);
		addRow(opPulse, selHBlank, 0, 0);
		addRow(opWrite, `SCU_IST_OFS, 32'h1E, 0);
		addRow(opRead, `SCU_IST_OFS, 0, 32'h06);
		addRow(opWrite, `SCU_IMS_OFS, 32'h19, 0);
		addRow(opWaitIrl, 0, 0, 4'h1);
		addRow(opVecRead, 4'hE, 0, 8'h41);
		addRow(opWaitIrl, 0, 0, 4'h2);
		addRow(opVecRead, 4'hD, 0, 8'h42);
		// IST write drops bit 2 only
		addRow(opWrite, `SCU_IMS_OFS, 32'h1B, 0);
		addRow(opPulse, selVBlank, 0, 0);
		addRow(opPulse, selHBlank, 0, 0);
		addRow(opWaitIrl, 0, 0, 4'h2);
		addRow(opWrite, `SCU_IST_OFS, 32'h1B, 0);
		addRow(opWaitIrl, 0, 0, 4'hF);
		addRow(opRead, `SCU_IST_OFS, 0, 32'h03);
		addRow(opVecRead, 4'h1, 0, 8'h00);
		// Timers, match on the third line after blank-out
		addRow(opWrite, `SCU_IMS_OFS, 32'h1F, 0);
		addRow(opWrite, `SCU_T0C_OFS, 32'h002, 0);
		addRow(opWrite, `SCU_T1S_OFS, 32'h001, 0);
		addRow(opWrite, `SCU_T1MD_OFS, 32'h001, 0);
		addRow(opPulse, selVBlank, 0, 0);
		addRow(opPulse, selHBlank, 0, 0);
		addRow(opPulse, selHBlank, 0, 0);
		addRow(opRead, `SCU_IST_OFS, 0, 32'h17);
		addRow(opPulse, selHBlank, 0, 0);
		addRow(opRead, `SCU_IST_OFS, 0, 32'h1F);
		addRow(opWrite, `SCU_IMS_OFS, 32'h17, 0);
		addRow(opWaitIrl, 0, 0, 4'h3);
		addRow(opVecRead, 4'hC, 0, 8'h43);
		addRow(opWrite, `SCU_IMS_OFS, 32'h0F, 0);
		addRow(opWaitIrl, 0, 0, 4'h4);
		addRow(opVecRead, 4'hB, 0, 8'h44);
		addRow(opWaitIrl, 0, 0, 4'hF);
		addRow(opRead, `SCU_IST_OFS, 0, 32'h07);
	endtask

	always @(negedge CLK) begin
		assert (!dut.props.violated)
		else stopRun("a bound assertion on the DUT ports failed");
	end

	initial begin
		row_t r;
		RST_N = 1'b0;
		regWrite = 1'b0;
		regAddr = '0;
		regWData = '0;
		regByteEnN = 4'hF;
		regRead = 1'b0;
		vecRead = 1'b0;
		vecLevel = '0;
		vBlankN = 1'b1;
		hBlankN = 1'b1;
		lfsrState = 8'd28;
		buildTable();
		repeat (10) @(negedge CLK);
		RST_N = 1'b1;
		foreach (rows[i]) begin
			r = rows[i];
			case (r.op)
				opWrite: writeReg(r.addr, r.data);
				opRead: readReg(r.addr, r.expVal);
				opPulse: pulseBlank(r.addr);
				opWaitIrl: waitIrl(r.expVal[3:0]);
				opVecRead: fetchVector(r.addr[3:0], r.expVal[7:0]);
				default: stopRun("unknown operation in the stimulus table");
			endcase
			idleGap();
		end
		if (dut.props.violated)
			stopRun("a bound assertion on the DUT ports failed");
		else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire
